//--- list.f
+incdir+verilog
verilog/axi_pkg.sv
verilog/noc_pkg.sv
verilog/chan_fifo.sv
verilog/fni_packetizer.sv
verilog/bni_depacketizer.sv
verilog/noc_axi_master_ni.sv
verification/noc_ni_props.sv
verification/tb_noc_axi_master_ni.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator, result decided from sim.log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_noc_axi_master_ni \
	-f list.f -o tb_sim \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| echo "simulation did not complete" >> sim.log
grep -q "TEST FAILED" sim.log && { echo "FAIL"; exit 1; }
grep -q "TEST OK" sim.log || { echo "FAIL"; exit 1; }
echo "PASS"
exit 0

//--- verification/noc_ni_props.sv
// ********************************************************************
// Handshake assertions for the AXI master network interface
// ********************************************************************
module noc_ni_props
	import axi_pkg::*;
	import noc_pkg::*;
(
	input logic      clk,
	input logic      i_rst,
	input fwd_flit_t o_fni_flit,
	input logic      o_fni_valid,
	input logic      i_fni_ready,
	input b_resp_t   o_b,
	input logic      o_b_valid,
	input logic      i_b_ready,
	input r_beat_t   o_r,
	input logic      o_r_valid,
	input logic      i_r_ready
);

	// A stalled transfer keeps valid and payload
	fni_hold: assert property (@(posedge clk) disable iff (i_rst)
		o_fni_valid && !i_fni_ready |=> o_fni_valid && $stable(o_fni_flit))
		else $error("forward flit changed before it was taken");

	b_hold: assert property (@(posedge clk) disable iff (i_rst)
		o_b_valid && !i_b_ready |=> o_b_valid && $stable(o_b))
		else $error("B beat changed before it was taken");

	r_hold: assert property (@(posedge clk) disable iff (i_rst)
		o_r_valid && !i_r_ready |=> o_r_valid && $stable(o_r))
		else $error("R beat changed before it was taken");

	reset_quiet: assert property (@(posedge clk)
		$fell(i_rst) |-> !o_fni_valid && !o_b_valid && !o_r_valid)
		else $error("output valid high in the cycle after reset");

endmodule

bind noc_axi_master_ni noc_ni_props props_i (
	.clk         (clk),
	.i_rst       (i_rst),
	.o_fni_flit  (o_fni_flit),
	.o_fni_valid (o_fni_valid),
	.i_fni_ready (i_fni_ready),
	.o_b         (o_b),
	.o_b_valid   (o_b_valid),
	.i_b_ready   (i_b_ready),
	.o_r         (o_r),
	.o_r_valid   (o_r_valid),
	.i_r_ready   (i_r_ready)
);

//--- verification/tb_noc_axi_master_ni.sv
// ********************************************************************
// Testbench for the AXI master network interface
// Plays the AXI master and the slave nodes, checks flits and responses
// ********************************************************************
`include "noc_params.svh"

module tb_noc_axi_master_ni
	import axi_pkg::*;
	import noc_pkg::*;
();

	localparam int NODE_ID = 5;
	localparam int NUM_WR = 24;
	localparam int NUM_RD = 24;
	localparam int NUM_OFF = 4;
	localparam int NUM_TXN = NUM_WR + NUM_RD + 2 * NUM_OFF;

	logic clk;
	logic i_rst;
	logic i_comm_disable;
	aw_req_t i_aw;
	logic i_aw_valid;
	logic o_aw_ready;
	w_beat_t i_w;
	logic i_w_valid;
	logic o_w_ready;
	ar_req_t i_ar;
	logic i_ar_valid;
	logic o_ar_ready;
	b_resp_t o_b;
	logic o_b_valid;
	logic i_b_ready;
	r_beat_t o_r;
	logic o_r_valid;
	logic i_r_ready;
	fwd_flit_t o_fni_flit;
	logic o_fni_valid;
	logic i_fni_ready;
	bwd_flit_t i_bni_flit;
	logic i_bni_valid;
	logic o_bni_ready;

	integer seed;
	int err_fwd = 0;
	int err_b = 0;
	int err_r = 0;
	int err_ctl = 0;
	int fwd_seen = 0;
	int b_seen = 0;
	int r_seen = 0;
	bit bwd_taken = 1'b0;

	aw_req_t wr_aw [NUM_WR + NUM_OFF];
	w_beat_t wr_w [NUM_WR + NUM_OFF];
	ar_req_t rd_ar [NUM_RD + NUM_OFF];
	fwd_flit_t exp_wr_q [$];
	fwd_flit_t exp_rd_q [$];
	b_resp_t exp_b_q [$];
	r_beat_t exp_r_q [$];
	bwd_flit_t bwd_q [$];

	noc_axi_master_ni #(.NODE_ID(NODE_ID)) dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ********************************************************************
	// Reference model
	function automatic fwd_flit_t ref_write_flit(input aw_req_t aw, input w_beat_t w);
		fwd_flit_t f;
		f.kind = KIND_WRITE;
		f.dest = node_t'(aw.addr >> (`AXI_ADDR_W - `NOC_NODE_W));
		f.src = node_t'(NODE_ID);
		f.id = aw.id;
		f.addr = aw.addr;
		f.data = w.data;
		f.strb = w.strb;
		return f;
	endfunction

	function automatic fwd_flit_t ref_read_flit(input ar_req_t ar);
		fwd_flit_t f;
		f.kind = KIND_READ;
		f.dest = node_t'(ar.addr >> (`AXI_ADDR_W - `NOC_NODE_W));
		f.src = node_t'(NODE_ID);
		f.id = ar.id;
		f.addr = ar.addr;
		f.data = '0;
		f.strb = '0;
		return f;
	endfunction

	// Slave node reply to a request flit
	function automatic bwd_flit_t slave_answer(input fwd_flit_t req);
		bwd_flit_t rsp;
		rsp.id = req.id;
		if (req.kind == KIND_WRITE) begin
			rsp.kind = KIND_BRESP;
			rsp.resp = req.addr[1:0];
			rsp.data = '0;
		end else begin
			rsp.kind = KIND_RDATA;
			rsp.resp = 2'b00;
			rsp.data = req.addr ^ 32'hA5A5A5A5;
		end
		return rsp;
	endfunction

	function automatic b_resp_t ref_b(input bwd_flit_t f);
		b_resp_t b;
		b.id = f.id;
		b.resp = f.resp;
		return b;
	endfunction

	function automatic r_beat_t ref_r(input bwd_flit_t f);
		r_beat_t r;
		r.id = f.id;
		r.data = f.data;
		r.resp = f.resp;
		return r;
	endfunction

	task automatic check_fwd(input fwd_flit_t got, input fwd_flit_t exp);
		if (got !== exp) begin
			err_fwd++;
			$display("ERR %0t: forward flit %h, expected %h", $time, got, exp);
		end
	endtask

	task automatic check_b(input b_resp_t got, input b_resp_t exp);
		if (got !== exp) begin
			err_b++;
			$display("ERR %0t: B beat %h, expected %h", $time, got, exp);
		end
	endtask

	task automatic check_r(input r_beat_t got, input r_beat_t exp);
		if (got !== exp) begin
			err_r++;
			$display("ERR %0t: R beat %h, expected %h", $time, got, exp);
		end
	endtask

	// ********************************************************************
	// AXI master
	task automatic issue_write(input aw_req_t aw, input w_beat_t w);
		bit aw_open;
		bit w_open;
		aw_open = 1'b1;
		w_open = 1'b1;
		exp_wr_q.push_back(ref_write_flit(aw, w));
		i_aw = aw;
		i_w = w;
		i_aw_valid = 1'b1;
		i_w_valid = 1'b1;
		while (aw_open || w_open) begin
			@(negedge clk);
			if (i_aw_valid && o_aw_ready) aw_open = 1'b0;
			if (i_w_valid && o_w_ready) w_open = 1'b0;
			@(posedge clk);
			#1;
			i_aw_valid = aw_open;
			i_w_valid = w_open;
		end
	endtask

	task automatic issue_read(input ar_req_t ar);
		bit ar_open;
		ar_open = 1'b1;
		exp_rd_q.push_back(ref_read_flit(ar));
		i_ar = ar;
		i_ar_valid = 1'b1;
		while (ar_open) begin
			@(negedge clk);
			if (o_ar_ready) ar_open = 1'b0;
			@(posedge clk);
			#1;
			i_ar_valid = ar_open;
		end
	endtask

	task automatic wait_drain(input int n_b, input int n_r);
		while (b_seen < n_b || r_seen < n_r) @(posedge clk);
	endtask

	// ********************************************************************
	// Slave nodes and random back-pressure
	initial begin : net_side
		forever begin
			@(posedge clk);
			#1;
			i_fni_ready = ($random(seed) & 3) != 0;
			i_b_ready = ($random(seed) & 3) != 0;
			i_r_ready = ($random(seed) & 3) != 0;
			if (bwd_taken) begin
				void'(bwd_q.pop_front());
				i_bni_valid = 1'b0;
			end
			if (!i_bni_valid && bwd_q.size() > 0 && ($random(seed) & 1) != 0) begin
				i_bni_flit = bwd_q[0];
				i_bni_valid = 1'b1;
			end
		end
	end

	// Transfers are sampled at the falling edge, ahead of the edge that takes them
	always @(negedge clk) begin
		bwd_taken = 1'b0;
		if (!i_rst) begin
			if (i_comm_disable && (o_aw_ready || o_ar_ready)) begin
				err_ctl++;
				$display("Error at %0t: AW or AR ready is high while disabled", $time);
			end
			if (o_fni_valid && i_fni_ready) begin
				fwd_seen++;
				if (o_fni_flit.kind == KIND_WRITE && exp_wr_q.size() > 0) begin
					check_fwd(o_fni_flit, exp_wr_q.pop_front());
				end else if (o_fni_flit.kind == KIND_READ && exp_rd_q.size() > 0) begin
					check_fwd(o_fni_flit, exp_rd_q.pop_front());
				end else begin
					err_ctl++;
					$display("Error at %0t: forward flit with no request behind it", $time);
				end
				bwd_q.push_back(slave_answer(o_fni_flit));
			end
			if (i_bni_valid && o_bni_ready) begin
				bwd_taken = 1'b1;
				if (i_bni_flit.kind == KIND_BRESP) exp_b_q.push_back(ref_b(i_bni_flit));
				else exp_r_q.push_back(ref_r(i_bni_flit));
			end
			if (o_b_valid && i_b_ready) begin
				b_seen++;
				if (exp_b_q.size() > 0) check_b(o_b, exp_b_q.pop_front());
				else begin
					err_ctl++;
					$display("Error at %0t: B beat with no response pending", $time);
				end
			end
			if (o_r_valid && i_r_ready) begin
				r_seen++;
				if (exp_r_q.size() > 0) check_r(o_r, exp_r_q.pop_front());
				else begin
					err_ctl++;
					$display("Error at %0t: R beat with no read data pending", $time);
				end
			end
		end
	end

	// ********************************************************************
	// Test sequence
	initial begin : main
		int fwd_mark;
		seed = 32'h932a;
		i_rst = 1'b1;
		i_comm_disable = 1'b0;
		i_aw = '0;
		i_aw_valid = 1'b0;
		i_w = '0;
		i_w_valid = 1'b0;
		i_ar = '0;
		i_ar_valid = 1'b0;
		i_b_ready = 1'b0;
		i_r_ready = 1'b0;
		i_fni_ready = 1'b0;
		i_bni_flit = '0;
		i_bni_valid = 1'b0;
		for (int i = 0; i < NUM_WR + NUM_OFF; i++) begin
			wr_aw[i].id = id_t'($random(seed));
			wr_aw[i].addr = addr_t'($random(seed));
			wr_w[i].data = data_t'($random(seed));
			wr_w[i].strb = strb_t'($random(seed));
		end
		for (int i = 0; i < NUM_RD + NUM_OFF; i++) begin
			rd_ar[i].id = id_t'($random(seed));
			rd_ar[i].addr = addr_t'($random(seed));
		end
		repeat (3) @(posedge clk);
		#1;
		i_rst = 1'b0;
		fork
			for (int k = 0; k < NUM_WR; k++) issue_write(wr_aw[k], wr_w[k]);
			for (int k = 0; k < NUM_RD; k++) issue_read(rd_ar[k]);
		join
		wait_drain(NUM_WR, NUM_RD);
		// Buffers are empty, so no flit may leave while disabled
		@(posedge clk);
		#1;
		i_comm_disable = 1'b1;
		fwd_mark = fwd_seen;
		fork
			for (int k = NUM_WR; k < NUM_WR + NUM_OFF; k++) issue_write(wr_aw[k], wr_w[k]);
			for (int k = NUM_RD; k < NUM_RD + NUM_OFF; k++) issue_read(rd_ar[k]);
			begin
				repeat (40) @(posedge clk);
				#1;
				if (fwd_seen != fwd_mark) begin
					err_ctl++;
					$display("Error at %0t: forward flit sent while disabled", $time);
				end
				i_comm_disable = 1'b0;
			end
		join
		wait_drain(NUM_WR + NUM_OFF, NUM_RD + NUM_OFF);
		repeat (5) @(posedge clk);
		$display("Errors: forward %0d, B %0d, R %0d, control %0d",
			err_fwd, err_b, err_r, err_ctl);
		if (err_fwd + err_b + err_r + err_ctl == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin : watchdog
		repeat (NUM_TXN * 40 + 200) @(posedge clk);
		$display("Timeout: pending writes %0d, reads %0d, B %0d, R %0d, backward flits %0d",
			exp_wr_q.size(), exp_rd_q.size(), exp_b_q.size(), exp_r_q.size(), bwd_q.size());
		$display("TEST FAILED");
		$finish;
	end

endmodule

//--- verilog/axi_pkg.sv
// ********************************************************************
// AXI channel types
// Payload structs for single-beat AW, W, AR, B and R transfers
// ********************************************************************
`include "noc_params.svh"

package axi_pkg;

	typedef logic [`AXI_ADDR_W-1:0] addr_t;
	typedef logic [`AXI_DATA_W-1:0] data_t;
	typedef logic [`AXI_ID_W-1:0] id_t;
	typedef logic [`AXI_DATA_W/8-1:0] strb_t;
	typedef logic [1:0] resp_t;

	typedef struct packed {
		id_t id;
		addr_t addr;
	} aw_req_t;

	typedef struct packed {
		data_t data;
		strb_t strb;
	} w_beat_t;

	typedef struct packed {
		id_t id;
		addr_t addr;
	} ar_req_t;

	typedef struct packed {
		id_t id;
		resp_t resp;
	} b_resp_t;

	typedef struct packed {
		id_t id;
		data_t data;
		resp_t resp;
	} r_beat_t;

endpackage

//--- verilog/bni_depacketizer.sv
// ********************************************************************
// Backward depacketizer
// Steers response flits into registered B and R channels
// ********************************************************************
module bni_depacketizer
	import axi_pkg::*;
	import noc_pkg::*;
(
	input  logic      clk,
	input  logic      i_rst,
	input  bwd_flit_t i_flit,
	input  logic      i_valid,
	output logic      o_ready,
	output b_resp_t   o_b,
	output logic      o_b_valid,
	input  logic      i_b_ready,
	output r_beat_t   o_r,
	output logic      o_r_valid,
	input  logic      i_r_ready
);

	logic b_free;
	logic r_free;
	logic accept;
	logic b_load;
	logic r_load;
	b_resp_t b_q;
	r_beat_t r_q;
	logic b_valid_q;
	logic r_valid_q;

	assign b_free = ~b_valid_q | i_b_ready;
	assign r_free = ~r_valid_q | i_r_ready;

	// Request kinds never belong here and are dropped
	always_comb begin
		case (i_flit.kind)
			KIND_BRESP: o_ready = b_free;
			KIND_RDATA: o_ready = r_free;
			default: o_ready = 1'b1;
		endcase
	end

	assign accept = i_valid & o_ready;
	assign b_load = accept & (i_flit.kind == KIND_BRESP);
	assign r_load = accept & (i_flit.kind == KIND_RDATA);

	always_ff @(posedge clk) begin
		if (b_load) begin
			b_q.id <= i_flit.id;
			b_q.resp <= i_flit.resp;
		end
		if (r_load) begin
			r_q.id <= i_flit.id;
			r_q.data <= i_flit.data;
			r_q.resp <= i_flit.resp;
		end
	end

	always_ff @(posedge clk) begin
		if (i_rst) begin
			b_valid_q <= 1'b0;
			r_valid_q <= 1'b0;
		end else begin
			if (b_load) begin
				b_valid_q <= 1'b1;
			end else if (i_b_ready) begin
				b_valid_q <= 1'b0;
			end
			if (r_load) begin
				r_valid_q <= 1'b1;
			end else if (i_r_ready) begin
				r_valid_q <= 1'b0;
			end
		end
	end

	assign o_b = b_q;
	assign o_b_valid = b_valid_q;
	assign o_r = r_q;
	assign o_r_valid = r_valid_q;

endmodule

//--- verilog/chan_fifo.sv
// ********************************************************************
// Channel FIFO
// Synchronous circular buffer for one AXI request channel
// ********************************************************************
module chan_fifo #(
	parameter int DEPTH = 2,
	parameter type T = logic
) (
	input  logic clk,
	input  logic i_rst,
	input  T     i_data,
	input  logic i_valid,
	output logic o_ready,
	output T     o_data,
	output logic o_valid,
	input  logic i_ready
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	T mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic push;
	logic pop;

	assign o_ready = (count != CNT_W'(DEPTH));
	assign o_valid = (count != '0);
	assign o_data = mem[rd_ptr];

	assign push = i_valid & o_ready;
	assign pop = o_valid & i_ready;

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= i_data;
		end
	end

	always_ff @(posedge clk) begin
		if (i_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// Simultaneous push and pop leave the count unchanged
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

//--- verilog/fni_packetizer.sv
// ********************************************************************
// Forward packetizer
// Picks a write or a read and builds the registered request flit
// ********************************************************************
`include "noc_params.svh"

module fni_packetizer
	import axi_pkg::*;
	import noc_pkg::*;
#(
	parameter int NODE_ID = 0
) (
	input  logic      clk,
	input  logic      i_rst,
	input  aw_req_t   i_aw,
	input  logic      i_aw_valid,
	output logic      o_aw_ready,
	input  w_beat_t   i_w,
	input  logic      i_w_valid,
	output logic      o_w_ready,
	input  ar_req_t   i_ar,
	input  logic      i_ar_valid,
	output logic      o_ar_ready,
	output fwd_flit_t o_flit,
	output logic      o_valid,
	input  logic      i_ready
);

	logic wr_elig;
	logic rd_elig;
	logic grant_wr;
	logic grant_rd;
	logic can_load;
	logic load;
	logic last_wr;
	fwd_flit_t next_flit;
	fwd_flit_t flit_q;
	logic flit_valid_q;

	// ********************************************************************
	// Arbitration
	assign wr_elig = i_aw_valid & i_w_valid;
	assign rd_elig = i_ar_valid;

	// Last winner loses a tie
	assign grant_wr = wr_elig & (~rd_elig | ~last_wr);
	assign grant_rd = rd_elig & ~grant_wr;

	assign can_load = ~flit_valid_q | i_ready;
	assign load = can_load & (grant_wr | grant_rd);

	// AW and W heads leave together
	assign o_aw_ready = load & grant_wr;
	assign o_w_ready = load & grant_wr;
	assign o_ar_ready = load & grant_rd;

	always_ff @(posedge clk) begin
		if (i_rst) begin
			last_wr <= 1'b0;
		end else if (load) begin
			last_wr <= grant_wr;
		end
	end

	// ********************************************************************
	// Flit assembly
	always_comb begin
		next_flit.src = node_t'(NODE_ID);
		if (grant_wr) begin
			next_flit.kind = KIND_WRITE;
			next_flit.dest = i_aw.addr[`DEST_MSB -: `NOC_NODE_W];
			next_flit.id = i_aw.id;
			next_flit.addr = i_aw.addr;
			next_flit.data = i_w.data;
			next_flit.strb = i_w.strb;
		end else begin
			next_flit.kind = KIND_READ;
			next_flit.dest = i_ar.addr[`DEST_MSB -: `NOC_NODE_W];
			next_flit.id = i_ar.id;
			next_flit.addr = i_ar.addr;
			next_flit.data = '0;
			next_flit.strb = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			flit_q <= next_flit;
		end
	end

	always_ff @(posedge clk) begin
		if (i_rst) begin
			flit_valid_q <= 1'b0;
		end else if (can_load) begin
			flit_valid_q <= grant_wr | grant_rd;
		end
	end

	assign o_flit = flit_q;
	assign o_valid = flit_valid_q;

endmodule

//--- verilog/noc_axi_master_ni.sv
// ********************************************************************
// AXI master network interface
// Buffers AXI requests and bridges them to forward and backward flits
// ********************************************************************
`include "noc_params.svh"

module noc_axi_master_ni
	import axi_pkg::*;
	import noc_pkg::*;
#(
	parameter int NODE_ID = 0
) (
	input  logic      clk,
	input  logic      i_rst,
	input  logic      i_comm_disable,
	input  aw_req_t   i_aw,
	input  logic      i_aw_valid,
	output logic      o_aw_ready,
	input  w_beat_t   i_w,
	input  logic      i_w_valid,
	output logic      o_w_ready,
	input  ar_req_t   i_ar,
	input  logic      i_ar_valid,
	output logic      o_ar_ready,
	output b_resp_t   o_b,
	output logic      o_b_valid,
	input  logic      i_b_ready,
	output r_beat_t   o_r,
	output logic      o_r_valid,
	input  logic      i_r_ready,
	output fwd_flit_t o_fni_flit,
	output logic      o_fni_valid,
	input  logic      i_fni_ready,
	input  bwd_flit_t i_bni_flit,
	input  logic      i_bni_valid,
	output logic      o_bni_ready
);

	logic aw_fifo_ready;
	logic ar_fifo_ready;
	aw_req_t aw_head;
	logic aw_head_valid;
	logic aw_pop;
	w_beat_t w_head;
	logic w_head_valid;
	logic w_pop;
	ar_req_t ar_head;
	logic ar_head_valid;
	logic ar_pop;

	// ********************************************************************
	// Request buffers
	// W stays open while disabled so writes can finish
	assign o_aw_ready = aw_fifo_ready & ~i_comm_disable;
	assign o_ar_ready = ar_fifo_ready & ~i_comm_disable;

	chan_fifo #(.DEPTH(`AW_FIFO_DEPTH), .T(aw_req_t)) aw_fifo_i (
		.clk     (clk),
		.i_rst   (i_rst),
		.i_data  (i_aw),
		.i_valid (i_aw_valid & ~i_comm_disable),
		.o_ready (aw_fifo_ready),
		.o_data  (aw_head),
		.o_valid (aw_head_valid),
		.i_ready (aw_pop)
	);

	chan_fifo #(.DEPTH(`W_FIFO_DEPTH), .T(w_beat_t)) w_fifo_i (
		.clk     (clk),
		.i_rst   (i_rst),
		.i_data  (i_w),
		.i_valid (i_w_valid),
		.o_ready (o_w_ready),
		.o_data  (w_head),
		.o_valid (w_head_valid),
		.i_ready (w_pop)
	);

	chan_fifo #(.DEPTH(`AR_FIFO_DEPTH), .T(ar_req_t)) ar_fifo_i (
		.clk     (clk),
		.i_rst   (i_rst),
		.i_data  (i_ar),
		.i_valid (i_ar_valid & ~i_comm_disable),
		.o_ready (ar_fifo_ready),
		.o_data  (ar_head),
		.o_valid (ar_head_valid),
		.i_ready (ar_pop)
	);

	// ********************************************************************
	// Network link
	fni_packetizer #(.NODE_ID(NODE_ID)) fni_i (
		.clk        (clk),
		.i_rst      (i_rst),
		.i_aw       (aw_head),
		.i_aw_valid (aw_head_valid),
		.o_aw_ready (aw_pop),
		.i_w        (w_head),
		.i_w_valid  (w_head_valid),
		.o_w_ready  (w_pop),
		.i_ar       (ar_head),
		.i_ar_valid (ar_head_valid),
		.o_ar_ready (ar_pop),
		.o_flit     (o_fni_flit),
		.o_valid    (o_fni_valid),
		.i_ready    (i_fni_ready)
	);

	bni_depacketizer bni_i (
		.clk       (clk),
		.i_rst     (i_rst),
		.i_flit    (i_bni_flit),
		.i_valid   (i_bni_valid),
		.o_ready   (o_bni_ready),
		.o_b       (o_b),
		.o_b_valid (o_b_valid),
		.i_b_ready (i_b_ready),
		.o_r       (o_r),
		.o_r_valid (o_r_valid),
		.i_r_ready (i_r_ready)
	);

endmodule

//--- verilog/noc_params.svh
// ********************************************************************
// Network interface parameters
// Bus widths, buffer depths and the destination field position
// ********************************************************************
`ifndef NOC_PARAMS_SVH
`define NOC_PARAMS_SVH

// AXI bus widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 32
`define AXI_ID_W 4

// Network node numbering
`define NOC_NODE_W 4
`define DEST_MSB 31

// Request buffer depths
`define AW_FIFO_DEPTH 2
`define W_FIFO_DEPTH 4
`define AR_FIFO_DEPTH 4

`endif

//--- verilog/noc_pkg.sv
// ********************************************************************
// Network flit types
// Forward request flits and backward response flits
// ********************************************************************
`include "noc_params.svh"

package noc_pkg;
	import axi_pkg::*;

	typedef logic [`NOC_NODE_W-1:0] node_t;

	typedef enum logic [1:0] {
		KIND_WRITE = 2'd0,
		KIND_READ  = 2'd1,
		KIND_BRESP = 2'd2,
		KIND_RDATA = 2'd3
	} flit_kind_e;

	// Request toward a slave node
	// Reads carry no data
	typedef struct packed {
		flit_kind_e kind;
		node_t dest;
		node_t src;
		id_t id;
		addr_t addr;
		data_t data;
		strb_t strb;
	} fwd_flit_t;

	// Response coming back to this master
	typedef struct packed {
		flit_kind_e kind;
		id_t id;
		resp_t resp;
		data_t data;
	} bwd_flit_t;

endpackage
